// ==== hdl/coef_write_sequencer.sv ====
`timescale 1ns/1ps

module coef_write_sequencer #(
    parameter int NUM_FILTERS = 4,
    parameter int MAX_TAPS    = 64
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  eq_reg_pkg::reg_strobes_t strobes,
    input  eq_reg_pkg::ctrl_regs_t   regs,
    output eq_reg_pkg::coef_write_t  coef_write,
    output eq_reg_pkg::eq_write_t    eq_write
);
    import eq_reg_pkg::*;

    logic [7:0] tap_ptr;    // Next tap to load
    logic [7:0] last_tap;   // Wrap point
    logic       filter_ok;  // Selected filter exists

    // Zero or oversized tap count means full length
    always_comb begin
        if (regs.num_fir_taps == 8'd0 || regs.num_fir_taps > MAX_TAPS)
            last_tap = 8'(MAX_TAPS - 1);
        else
            last_tap = regs.num_fir_taps - 8'd1;
    end

    assign filter_ok = (regs.filter_sel < NUM_FILTERS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap_ptr    <= '0;
            coef_write <= '0;
            eq_write   <= '0;
        end else begin
            coef_write.valid <= 1'b0;  // Single-cycle valids
            eq_write.valid   <= 1'b0;
            if (strobes.filter_sel_wr) begin
                tap_ptr <= '0;         // New filter starts at tap 0
            end else if (strobes.coef_wr && filter_ok) begin
                coef_write.valid  <= 1'b1;
                coef_write.filter <= regs.filter_sel;
                coef_write.tap    <= tap_ptr;
                coef_write.value  <= {regs.fir_coef_msb, regs.fir_coef_lsb};
                // >= also catches a tap count lowered mid-load
                tap_ptr <= (tap_ptr >= last_tap) ? 8'd0 : tap_ptr + 8'd1;
            end
            if (strobes.gain_wr && filter_ok) begin
                eq_write.valid  <= 1'b1;
                eq_write.filter <= regs.filter_sel;
                eq_write.gain   <= {regs.eq_gain_msb, regs.eq_gain_lsb};
            end
        end
    end

endmodule : coef_write_sequencer

// ==== hdl/ctrl_register_bank.sv ====
`timescale 1ns/1ps

module ctrl_register_bank (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                rd_strobe,
    input  logic                                wr_strobe,
    input  spi_frame_pkg::spi_access_t          access,
    input  eq_reg_pkg::status_in_t              status_in,
    output logic [spi_frame_pkg::DATA_BITS-1:0] read_data,
    output eq_reg_pkg::ctrl_regs_t              regs,
    output eq_reg_pkg::reg_strobes_t            strobes
);
    import spi_frame_pkg::*;
    import eq_reg_pkg::*;

    logic [DATA_BITS-1:0] rd_mux;  // Addressed byte, combinational

    ////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '0;  // Everything starts at zero
        end else if (wr_strobe) begin
            case (access.addr)
                AUD_CONTROL:  regs.aud_control  <= access.wdata;
                NUM_FIR_TAPS: regs.num_fir_taps <= access.wdata;
                FILTER_SEL:   regs.filter_sel   <= access.wdata;
                FIR_COEF_LSB: regs.fir_coef_lsb <= access.wdata;
                FIR_COEF_MSB: regs.fir_coef_msb <= access.wdata;
                SRAM_CONTROL: regs.sram_control <= access.wdata;
                AUX:          regs.aux          <= access.wdata;
                SRAM_ADDR:    regs.sram_addr    <= access.wdata;
                SPI_TO_SRAM:  regs.spi_to_sram  <= access.wdata;
                MPIO_CONTROL: regs.mpio_control <= access.wdata;
                SPI_TO_MPIO:  regs.spi_to_mpio  <= access.wdata;
                EQ_GAIN_LSB:  regs.eq_gain_lsb  <= access.wdata;
                EQ_GAIN_MSB:  regs.eq_gain_msb  <= access.wdata;
                default: ;    // Read-only and unmapped are ignored
            endcase
        end
    end

    ////////////////////////////////////////
    // Read multiplexer
    ////////////////////////////////////////
    always_comb begin
        case (access.addr)
            AUD_CONTROL:  rd_mux = regs.aud_control;
            AUD_STATUS:   rd_mux = status_in.audio_status;
            NUM_FIR_TAPS: rd_mux = regs.num_fir_taps;
            FILTER_SEL:   rd_mux = regs.filter_sel;
            FIR_COEF_LSB: rd_mux = regs.fir_coef_lsb;
            FIR_COEF_MSB: rd_mux = regs.fir_coef_msb;
            SRAM_CONTROL: rd_mux = regs.sram_control;
            AUX:          rd_mux = regs.aux;
            SRAM_ADDR:    rd_mux = regs.sram_addr;
            SPI_TO_SRAM:  rd_mux = regs.spi_to_sram;
            SRAM_TO_SPI:  rd_mux = status_in.sram_to_spi;  // From SRAM controller
            MPIO_CONTROL: rd_mux = regs.mpio_control;
            SPI_TO_MPIO:  rd_mux = regs.spi_to_mpio;
            MPIO_TO_SPI:  rd_mux = status_in.mpio_to_spi;  // From MPIO controller
            EQ_GAIN_LSB:  rd_mux = regs.eq_gain_lsb;
            EQ_GAIN_MSB:  rd_mux = regs.eq_gain_msb;
            STATUS:       rd_mux = status_in.status;       // General status
            default:      rd_mux = UNMAPPED_READ;
        endcase
    end

    // Captured once per read frame and held for the shifter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            read_data <= '0;
        else if (rd_strobe)
            read_data <= rd_mux;
    end

    ////////////////////////////////////////
    // Write strobes toward the sequencer
    ////////////////////////////////////////
    // Same edge as the register update, so the
    // sequencer sees the new MSB with its strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            strobes <= '0;
        end else begin
            strobes.coef_wr       <= wr_strobe && (access.addr == FIR_COEF_MSB);
            strobes.gain_wr       <= wr_strobe && (access.addr == EQ_GAIN_MSB);
            strobes.filter_sel_wr <= wr_strobe && (access.addr == FILTER_SEL);
        end
    end

endmodule : ctrl_register_bank

// ==== hdl/eq_reg_pkg.sv ====
package eq_reg_pkg;

    typedef logic [spi_frame_pkg::ADDR_BITS-1:0] reg_addr_t;
    typedef logic [spi_frame_pkg::DATA_BITS-1:0] reg_byte_t;

    ////////////////////////////////////////
    // Address map
    ////////////////////////////////////////
    localparam reg_addr_t AUD_CONTROL  = 7'h00;  // Audio control
    localparam reg_addr_t AUD_STATUS   = 7'h01;  // Read only, from audio core
    localparam reg_addr_t NUM_FIR_TAPS = 7'h02;  // Taps per filter, 0 means max
    localparam reg_addr_t FILTER_SEL   = 7'h03;  // Filter being loaded
    localparam reg_addr_t FIR_COEF_LSB = 7'h04;
    localparam reg_addr_t FIR_COEF_MSB = 7'h05;  // Write triggers coefficient load
    localparam reg_addr_t SRAM_CONTROL = 7'h06;
    localparam reg_addr_t AUX          = 7'h07;  // Scratch
    localparam reg_addr_t SRAM_ADDR    = 7'h08;  // SRAM start address
    localparam reg_addr_t SPI_TO_SRAM  = 7'h09;
    localparam reg_addr_t SRAM_TO_SPI  = 7'h0A;  // Read only
    localparam reg_addr_t MPIO_CONTROL = 7'h0B;
    localparam reg_addr_t SPI_TO_MPIO  = 7'h0C;
    localparam reg_addr_t MPIO_TO_SPI  = 7'h0D;  // Read only
    localparam reg_addr_t EQ_GAIN_LSB  = 7'h0E;
    localparam reg_addr_t EQ_GAIN_MSB  = 7'h0F;  // Write triggers gain load
    localparam reg_addr_t STATUS       = 7'h10;  // Read only, general status

    localparam reg_byte_t UNMAPPED_READ = 8'h99;  // Unmapped read pattern

    // Writable registers
    typedef struct packed {
        reg_byte_t aud_control;
        reg_byte_t num_fir_taps;
        reg_byte_t filter_sel;
        reg_byte_t fir_coef_lsb;
        reg_byte_t fir_coef_msb;
        reg_byte_t sram_control;
        reg_byte_t aux;
        reg_byte_t sram_addr;
        reg_byte_t spi_to_sram;
        reg_byte_t mpio_control;
        reg_byte_t spi_to_mpio;
        reg_byte_t eq_gain_lsb;
        reg_byte_t eq_gain_msb;
    } ctrl_regs_t;

    // Read-only bytes from the rest of the chip
    typedef struct packed {
        reg_byte_t status;
        reg_byte_t audio_status;
        reg_byte_t sram_to_spi;
        reg_byte_t mpio_to_spi;
    } status_in_t;

    typedef struct packed {
        logic coef_wr;        // FIR_COEF_MSB written
        logic gain_wr;        // EQ_GAIN_MSB written
        logic filter_sel_wr;  // FILTER_SEL written
    } reg_strobes_t;

    typedef struct packed {
        logic        valid;
        logic [7:0]  filter;
        logic [7:0]  tap;
        logic [15:0] value;
    } coef_write_t;

    typedef struct packed {
        logic        valid;
        logic [7:0]  filter;
        logic [15:0] gain;
    } eq_write_t;

endpackage : eq_reg_pkg

// ==== hdl/spi_eq_ctrl_top.sv ====
`timescale 1ns/1ps

module spi_eq_ctrl_top #(
    parameter int NUM_FILTERS = 4,   // Filters in the FIR core
    parameter int MAX_TAPS    = 64   // Longest filter
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cs_n,
    input  logic                    sclk,
    input  logic                    mosi,
    input  eq_reg_pkg::status_in_t  status_in,
    output logic                    miso,     // Joined with miso_oe at chip level
    output logic                    miso_oe,
    output eq_reg_pkg::ctrl_regs_t  regs,
    output eq_reg_pkg::coef_write_t coef_write,
    output eq_reg_pkg::eq_write_t   eq_write
);
    import spi_frame_pkg::*;
    import eq_reg_pkg::*;

    logic                 rd_strobe;
    logic                 wr_strobe;
    spi_access_t          access;
    logic [DATA_BITS-1:0] read_data;
    reg_strobes_t         strobes;

    ////////////////////////////////////////
    // Producer, buffer, consumer
    ////////////////////////////////////////
    spi_frame_receiver u_receiver (
        .clk       (clk),
        .rst_n     (rst_n),
        .cs_n      (cs_n),
        .sclk      (sclk),
        .mosi      (mosi),
        .read_data (read_data),
        .miso      (miso),
        .miso_oe   (miso_oe),
        .rd_strobe (rd_strobe),
        .wr_strobe (wr_strobe),
        .access    (access)
    );

    ctrl_register_bank u_reg_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_strobe (rd_strobe),
        .wr_strobe (wr_strobe),
        .access    (access),
        .status_in (status_in),
        .read_data (read_data),
        .regs      (regs),
        .strobes   (strobes)
    );

    coef_write_sequencer #(
        .NUM_FILTERS (NUM_FILTERS),
        .MAX_TAPS    (MAX_TAPS)
    ) u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .strobes    (strobes),
        .regs       (regs),
        .coef_write (coef_write),
        .eq_write   (eq_write)
    );

endmodule : spi_eq_ctrl_top

// ==== hdl/spi_frame_pkg.sv ====
package spi_frame_pkg;

    ////////////////////////////////////////
    // Frame layout
    ////////////////////////////////////////

    // Frame is R/W bit, address, data, all MSB first
    localparam int ADDR_BITS  = 7;                          // Register address
    localparam int DATA_BITS  = 8;                          // Data byte
    localparam int FRAME_BITS = 1 + ADDR_BITS + DATA_BITS;  // 16 sclk per frame

    // Access as seen by the register bank
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;   // Target register
        logic [DATA_BITS-1:0] wdata;  // Only meaningful on writes
    } spi_access_t;

endpackage : spi_frame_pkg

// ==== hdl/spi_frame_receiver.sv ====
`timescale 1ns/1ps

module spi_frame_receiver (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cs_n,
    input  logic                                sclk,
    input  logic                                mosi,
    input  logic [spi_frame_pkg::DATA_BITS-1:0] read_data,
    output logic                                miso,
    output logic                                miso_oe,
    output logic                                rd_strobe,
    output logic                                wr_strobe,
    output spi_frame_pkg::spi_access_t          access
);
    import spi_frame_pkg::*;

    localparam int CNT_W = $clog2(FRAME_BITS + 1);

    // Pin synchronizers
    logic cs_meta, cs_sync;
    logic sclk_meta, sclk_sync, sclk_last;
    logic mosi_meta, mosi_sync;

    logic             sclk_rise, sclk_fall;
    logic [CNT_W-1:0] bit_cnt;          // Rising edges seen this frame
    logic [DATA_BITS-1:0] shift_in;     // Incoming bits
    logic [DATA_BITS-1:0] shift_out;    // Read byte being serialized
    logic             rw_q;             // 1 = read frame
    logic             rd_pend;          // read_data lands next cycle
    logic             oe_q;
    logic [ADDR_BITS-1:0] addr_q;
    logic [DATA_BITS-1:0] wdata_q;

    ////////////////////////////////////////
    // Synchronize and detect sclk edges
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_meta   <= 1'b1;  // Idle deselected
            cs_sync   <= 1'b1;
            sclk_meta <= 1'b0;  // Mode 0 idles low
            sclk_sync <= 1'b0;
            sclk_last <= 1'b0;
            mosi_meta <= 1'b0;
            mosi_sync <= 1'b0;
        end else begin
            cs_meta   <= cs_n;
            cs_sync   <= cs_meta;
            sclk_meta <= sclk;
            sclk_sync <= sclk_meta;
            sclk_last <= sclk_sync;
            mosi_meta <= mosi;
            mosi_sync <= mosi_meta;
        end
    end

    assign sclk_rise = !cs_sync && sclk_sync && !sclk_last;
    assign sclk_fall = !cs_sync && !sclk_sync && sclk_last;

    ////////////////////////////////////////
    // Frame shifter and strobes
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt   <= '0;
            shift_in  <= '0;
            shift_out <= '0;
            rw_q      <= 1'b0;
            rd_strobe <= 1'b0;
            wr_strobe <= 1'b0;
            rd_pend   <= 1'b0;
            oe_q      <= 1'b0;
            miso      <= 1'b0;
        end else begin
            rd_strobe <= 1'b0;      // Pulses by default
            wr_strobe <= 1'b0;
            rd_pend   <= rd_strobe; // Bank registers read_data meanwhile
            if (cs_sync) begin
                // Deselected so any partial frame is dropped
                bit_cnt   <= '0;
                shift_in  <= '0;
                shift_out <= '0;
                rw_q      <= 1'b0;
                oe_q      <= 1'b0;
            end else begin
                if (sclk_rise) begin
                    shift_in <= {shift_in[DATA_BITS-2:0], mosi_sync};
                    if (bit_cnt != CNT_W'(FRAME_BITS))
                        bit_cnt <= bit_cnt + 1'b1;  // Saturate past frame end
                    // 8th bit completes the command
                    if (bit_cnt == CNT_W'(ADDR_BITS)) begin
                        rw_q      <= shift_in[ADDR_BITS-1];  // First bit of frame
                        rd_strobe <= shift_in[ADDR_BITS-1];
                    end
                    // 16th bit completes the data
                    if (bit_cnt == CNT_W'(FRAME_BITS - 1))
                        wr_strobe <= !rw_q;
                end
                if (rd_pend) begin
                    shift_out <= read_data;
                end else if (sclk_fall && rw_q && bit_cnt > CNT_W'(ADDR_BITS)
                             && bit_cnt < CNT_W'(FRAME_BITS)) begin
                    miso      <= shift_out[DATA_BITS-1];  // MSB first
                    shift_out <= {shift_out[DATA_BITS-2:0], 1'b0};
                    oe_q      <= 1'b1;                    // Data phase begins
                end
            end
        end
    end

    // Address and data payload
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q  <= '0;
            wdata_q <= '0;
        end else begin
            if (sclk_rise && bit_cnt == CNT_W'(ADDR_BITS))
                addr_q <= {shift_in[ADDR_BITS-2:0], mosi_sync};
            if (sclk_rise && bit_cnt == CNT_W'(FRAME_BITS - 1))
                wdata_q <= {shift_in[DATA_BITS-2:0], mosi_sync};
        end
    end

    assign access.addr  = addr_q;
    assign access.wdata = wdata_q;

    // Raw cs_n drops the enable at once since the sync path lags 2 cycles
    assign miso_oe = oe_q && !cs_n;

endmodule : spi_frame_receiver

// ==== spi_eq_ctrl.f ====
hdl/spi_frame_pkg.sv
hdl/eq_reg_pkg.sv
hdl/spi_frame_receiver.sv
hdl/ctrl_register_bank.sv
hdl/coef_write_sequencer.sv
hdl/spi_eq_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/spi_eq_ctrl_checker.sv
testbench/spi_eq_ctrl_tb.sv

// ==== testbench/spi_eq_ctrl_checker.sv ====
`timescale 1ns/1ps

module spi_eq_ctrl_checker #(
    parameter int NUM_FILTERS = 4,
    parameter int MAX_TAPS    = 64
) (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     cs_n,
    input logic                     miso_oe,
    input logic                     rd_strobe,
    input logic                     wr_strobe,
    input eq_reg_pkg::reg_strobes_t strobes,
    input eq_reg_pkg::coef_write_t  coef_write,
    input eq_reg_pkg::eq_write_t    eq_write
);
    int unsigned fail_count = 0;  // Failed assertions so far
    logic [6:0]  pulses;          // All single-cycle pulses

    assign pulses = {rd_strobe, wr_strobe, strobes, coef_write.valid, eq_write.valid};

    ////////////////////////////////////////
    // Strobe shape
    ////////////////////////////////////////
    strobe_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_strobe && wr_strobe))
    else begin
        $error("rd_strobe and wr_strobe high together");
        fail_count++;
    end

    // Every pulse drops after one cycle even when the next stage follows at once
    strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
        (pulses & $past(pulses)) == '0)
    else begin
        $error("strobe or valid held longer than one cycle");
        fail_count++;
    end

    ////////////////////////////////////////
    // Output sanity
    ////////////////////////////////////////
    oe_deselected: assert property (@(posedge clk) disable iff (!rst_n)
        cs_n |-> !miso_oe)                     // Never drive MISO when deselected
    else begin
        $error("miso_oe high while cs_n high");
        fail_count++;
    end

    coef_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        coef_write.valid |-> (coef_write.filter < NUM_FILTERS && coef_write.tap < MAX_TAPS))
    else begin
        $error("coef_write filter or tap out of range");
        fail_count++;
    end

endmodule : spi_eq_ctrl_checker

bind spi_eq_ctrl_top spi_eq_ctrl_checker #(
    .NUM_FILTERS (NUM_FILTERS),
    .MAX_TAPS    (MAX_TAPS)
) assert_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cs_n       (cs_n),
    .miso_oe    (miso_oe),
    .rd_strobe  (rd_strobe),
    .wr_strobe  (wr_strobe),
    .strobes    (strobes),
    .coef_write (coef_write),
    .eq_write   (eq_write)
);

// ==== testbench/spi_eq_ctrl_tb.sv ====
`timescale 1ns/1ps

module spi_eq_ctrl_tb;
    import eq_reg_pkg::*;

    localparam int NUM_FILTERS = 4;
    localparam int MAX_TAPS    = 64;
    localparam int HALF        = 8;    // clk per sclk half-period
    localparam int GAP         = 10;   // cs_n high between frames
    localparam int DRAIN_LIMIT = 200;  // Cycles allowed for pending writes

    logic        clk;
    logic        rst_n;
    logic        cs_n;
    logic        sclk;
    logic        mosi;
    logic        miso;
    logic        miso_oe;
    status_in_t  status_in;
    ctrl_regs_t  regs;
    coef_write_t coef_write;
    eq_write_t   eq_write;

    logic [7:0]  model_regs [0:127];  // Register model indexed by address
    logic [7:0]  model_tap;           // Tap pointer model
    coef_write_t exp_coef_q[$];
    eq_write_t   exp_eq_q[$];
    logic [7:0]  seen_taps[$];
    int          tap_order [7] = '{0, 1, 2, 3, 4, 0, 1};  // 5-tap wrap
    int          errors;
    int          checks;
    int          test_num;
    int          tests_failed;
    int          test_err_base;

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(10)) clock_i (.clk(clk), .rst_n(rst_n));

    spi_eq_ctrl_top #(
        .NUM_FILTERS (NUM_FILTERS),
        .MAX_TAPS    (MAX_TAPS)
    ) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cs_n       (cs_n),
        .sclk       (sclk),
        .mosi       (mosi),
        .status_in  (status_in),
        .miso       (miso),
        .miso_oe    (miso_oe),
        .regs       (regs),
        .coef_write (coef_write),
        .eq_write   (eq_write)
    );

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////
    function automatic bit is_writable(input logic [6:0] addr);
        return addr <= EQ_GAIN_MSB && addr != AUD_STATUS
            && addr != SRAM_TO_SPI && addr != MPIO_TO_SPI;
    endfunction

    function automatic logic [7:0] expected_read(input logic [6:0] addr);
        case (addr)
            AUD_STATUS:  return status_in.audio_status;
            SRAM_TO_SPI: return status_in.sram_to_spi;
            MPIO_TO_SPI: return status_in.mpio_to_spi;
            STATUS:      return status_in.status;
            default:     return is_writable(addr) ? model_regs[addr] : UNMAPPED_READ;
        endcase
    endfunction

    function automatic ctrl_regs_t expected_regs();
        ctrl_regs_t r;
        r.aud_control  = model_regs[AUD_CONTROL];
        r.num_fir_taps = model_regs[NUM_FIR_TAPS];
        r.filter_sel   = model_regs[FILTER_SEL];
        r.fir_coef_lsb = model_regs[FIR_COEF_LSB];
        r.fir_coef_msb = model_regs[FIR_COEF_MSB];
        r.sram_control = model_regs[SRAM_CONTROL];
        r.aux          = model_regs[AUX];
        r.sram_addr    = model_regs[SRAM_ADDR];
        r.spi_to_sram  = model_regs[SPI_TO_SRAM];
        r.mpio_control = model_regs[MPIO_CONTROL];
        r.spi_to_mpio  = model_regs[SPI_TO_MPIO];
        r.eq_gain_lsb  = model_regs[EQ_GAIN_LSB];
        r.eq_gain_msb  = model_regs[EQ_GAIN_MSB];
        return r;
    endfunction

    // Tap count of 0 or above MAX_TAPS means MAX_TAPS
    function automatic logic [7:0] next_tap(input logic [7:0] tap);
        int count;
        count = model_regs[NUM_FIR_TAPS];
        if (count == 0 || count > MAX_TAPS)
            count = MAX_TAPS;
        return (tap >= count - 1) ? 8'd0 : tap + 8'd1;
    endfunction

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic idle_clks(input int n);
        repeat (n) @(posedge clk);
    endtask

    ////////////////////////////////////////
    // SPI master, mode 0
    ////////////////////////////////////////
    task automatic spi_frame(input logic rw, input logic [6:0] addr, input logic [7:0] wdata,
                             input int nbits, output logic [7:0] rdata);
        logic [15:0] frame;
        int          i;
        frame = {rw, addr, wdata};
        rdata = 8'h00;
        @(posedge clk);
        cs_n <= 1'b0;
        mosi <= frame[15];                      // First bit set up before sclk
        idle_clks(HALF - 1);
        for (i = 0; i < nbits; i++) begin
            @(negedge clk);
            check_value("miso_oe", miso_oe, rw && i >= 8);  // Only in read data phase
            if (i >= 8)
                rdata = {rdata[6:0], miso};     // Sample just before rising sclk
            @(posedge clk);
            sclk <= 1'b1;
            idle_clks(HALF - 1);
            @(posedge clk);
            sclk <= 1'b0;
            mosi <= (i < 15) ? frame[14 - i] : 1'b0;
            idle_clks(HALF - 1);
        end
        @(posedge clk);
        cs_n <= 1'b1;                           // End or abort the frame
        mosi <= 1'b0;
        idle_clks(GAP);
    endtask

    // Expected pulses are queued before the frame goes out
    task automatic spi_write(input logic [6:0] addr, input logic [7:0] data);
        logic [7:0] filter;
        logic [7:0] unused;
        if (is_writable(addr))
            model_regs[addr] = data;
        filter = model_regs[FILTER_SEL];
        if (addr == FILTER_SEL)
            model_tap = 8'd0;
        if (addr == FIR_COEF_MSB && filter < NUM_FILTERS) begin
            exp_coef_q.push_back({1'b1, filter, model_tap, data, model_regs[FIR_COEF_LSB]});
            model_tap = next_tap(model_tap);
        end
        if (addr == EQ_GAIN_MSB && filter < NUM_FILTERS)
            exp_eq_q.push_back({1'b1, filter, data, model_regs[EQ_GAIN_LSB]});
        spi_frame(1'b0, addr, data, 16, unused);
    endtask

    task automatic read_check(input logic [6:0] addr);
        logic [7:0] exp;
        logic [7:0] got;
        exp = expected_read(addr);
        spi_frame(1'b1, addr, 8'h00, 16, got);
        check_value($sformatf("read of 0x%02h", addr), got, exp);
    endtask

    task automatic wait_writes_done();
        int n;
        n = 0;
        while ((exp_coef_q.size() != 0 || exp_eq_q.size() != 0) && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_coef_q.size() != 0 || exp_eq_q.size() != 0) begin
            errors++;
            $display("Timeout: coefficient or gain writes still missing after %0d cycles", n);
            exp_coef_q.delete();
            exp_eq_q.delete();
        end
        idle_clks(20);                          // Room for stray pulses
    endtask

    task automatic finish_test(input string name);
        wait_writes_done();
        test_num++;
        if (errors != test_err_base)
            tests_failed++;
        $display("Test %0d, %s: %s", test_num, name, (errors == test_err_base) ? "PASS" : "FAIL");
        test_err_base = errors;
    endtask

    ////////////////////////////////////////
    // Output comparison
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n && coef_write.valid) begin
            seen_taps.push_back(coef_write.tap);
            if (exp_coef_q.size() == 0) begin
                errors++;
                $display("Unexpected coefficient write at %0t ns, filter %0d tap %0d",
                         $time, coef_write.filter, coef_write.tap);
            end else begin
                check_value("coef_write", coef_write, exp_coef_q.pop_front());
            end
        end
        if (rst_n && eq_write.valid) begin
            if (exp_eq_q.size() == 0) begin
                errors++;
                $display("Unexpected gain write at %0t ns, filter %0d", $time, eq_write.filter);
            end else begin
                check_value("eq_write", eq_write, exp_eq_q.pop_front());
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        int         n;
        logic [7:0] rd_byte;
        void'($urandom(77211));
        cs_n      = 1'b1;
        sclk      = 1'b0;
        mosi      = 1'b0;
        status_in = '0;
        errors    = 0;
        checks    = 0;
        test_num  = 0;
        tests_failed  = 0;
        test_err_base = 0;
        model_tap = 8'd0;
        foreach (model_regs[a])
            model_regs[a] = 8'h00;

        n = 0;
        while (rst_n !== 1'b1 && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("Timeout: reset was never released");
        end
        idle_clks(5);

        // Reset values
        check_value("regs after reset", regs, '0);
        check_value("miso_oe after reset", miso_oe, 1'b0);
        for (n = 0; n <= EQ_GAIN_MSB; n++)
            if (is_writable(7'(n)))
                read_check(7'(n));
        finish_test("reset values");

        // Random writes, then read-only and unmapped writes
        for (n = 0; n <= EQ_GAIN_MSB; n++) begin
            if (is_writable(7'(n))) begin
                spi_write(7'(n), 8'($urandom));
                check_value($sformatf("regs after write to 0x%02h", n), regs, expected_regs());
            end
        end
        spi_write(AUD_STATUS, 8'($urandom));
        spi_write(SRAM_TO_SPI, 8'($urandom));
        spi_write(MPIO_TO_SPI, 8'($urandom));
        spi_write(STATUS, 8'($urandom));
        spi_write(7'h55, 8'($urandom));
        check_value("regs after read-only writes", regs, expected_regs());
        for (n = 0; n <= EQ_GAIN_MSB; n++)
            if (is_writable(7'(n)))
                read_check(7'(n));
        finish_test("register write and read back");

        // Status bytes and unmapped addresses
        @(posedge clk);
        status_in <= $urandom;
        idle_clks(2);
        read_check(AUD_STATUS);
        read_check(STATUS);
        read_check(SRAM_TO_SPI);
        read_check(MPIO_TO_SPI);
        read_check(7'h11);
        read_check(7'h40);
        read_check(7'h7F);
        finish_test("status and unmapped reads");

        // Seven coefficients into a 5-tap filter
        spi_write(FILTER_SEL, 8'($urandom_range(NUM_FILTERS - 1)));
        spi_write(NUM_FIR_TAPS, 8'd5);
        seen_taps.delete();
        repeat (7) begin
            spi_write(FIR_COEF_LSB, 8'($urandom));
            spi_write(FIR_COEF_MSB, 8'($urandom));
        end
        wait_writes_done();
        check_value("number of coefficient writes", seen_taps.size(), 7);
        foreach (tap_order[i])
            check_value($sformatf("tap of coefficient %0d", i),
                        (i < seen_taps.size()) ? seen_taps[i] : 8'hFF, tap_order[i]);
        spi_write(FILTER_SEL, 8'(NUM_FILTERS));  // Out of range so writes are dropped
        spi_write(FIR_COEF_LSB, 8'($urandom));
        spi_write(FIR_COEF_MSB, 8'($urandom));
        spi_write(FILTER_SEL, 8'hC8);
        spi_write(FIR_COEF_MSB, 8'($urandom));
        finish_test("coefficient sequencing");

        // Gain write, then aborted frames after 10 bits
        spi_write(FILTER_SEL, 8'($urandom_range(NUM_FILTERS - 1)));
        spi_write(EQ_GAIN_LSB, 8'($urandom));
        spi_write(EQ_GAIN_MSB, 8'($urandom));
        wait_writes_done();
        spi_frame(1'b0, EQ_GAIN_MSB, ~model_regs[EQ_GAIN_MSB], 10, rd_byte);
        spi_frame(1'b0, AUX, ~model_regs[AUX], 10, rd_byte);
        idle_clks(20);
        check_value("regs after aborted frames", regs, expected_regs());
        read_check(AUX);                        // Receiver recovers
        finish_test("gain writes and aborted frames");

        $display("Tests run %0d, failed %0d; checks %0d, errors %0d, assertion failures %0d",
                 test_num, tests_failed, checks, errors, dut_i.assert_i.fail_count);
        if (errors == 0 && dut_i.assert_i.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : spi_eq_ctrl_tb

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;                          // Asserted from time zero
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end
endmodule : tb_clock_gen
